//--- common/isa_pkg.sv
package isa_pkg;

    // major opcodes
    localparam logic [5:0] OPC_SPECIAL  = 6'h00;
    localparam logic [5:0] OPC_ADDIU    = 6'h09;
    localparam logic [5:0] OPC_SLTIU    = 6'h0b;
    localparam logic [5:0] OPC_ORI      = 6'h0d;
    localparam logic [5:0] OPC_LUI      = 6'h0f;
    localparam logic [5:0] OPC_SPECIAL2 = 6'h1c;

    // SPECIAL funct field
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_SLTU  = 6'h2b;

    // SPECIAL2 funct field
    localparam logic [5:0] FN2_MADDU = 6'h01;
    localparam logic [5:0] FN2_MSUBU = 6'h05;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_view_t;

    // same 32 bits, register form or immediate form
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_word_u;

endpackage

//--- common/core_pkg.sv
package core_pkg;

    // lane 0 is the older slot
    localparam int NUM_LANES  = 2;
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int OP_W       = 4;

    // internal ops, immediate forms fold onto register forms
    localparam logic [OP_W-1:0] OP_NOP   = 4'd0;
    localparam logic [OP_W-1:0] OP_ADDU  = 4'd1;
    localparam logic [OP_W-1:0] OP_SUBU  = 4'd2;
    localparam logic [OP_W-1:0] OP_AND   = 4'd3;
    localparam logic [OP_W-1:0] OP_OR    = 4'd4;
    localparam logic [OP_W-1:0] OP_XOR   = 4'd5;
    localparam logic [OP_W-1:0] OP_SLT   = 4'd6;
    localparam logic [OP_W-1:0] OP_SLTU  = 4'd7;
    localparam logic [OP_W-1:0] OP_LUI   = 4'd8;
    // HI/LO group, no general register write
    localparam logic [OP_W-1:0] OP_MULTU = 4'd9;
    localparam logic [OP_W-1:0] OP_MADDU = 4'd10;
    localparam logic [OP_W-1:0] OP_MSUBU = 4'd11;
    localparam logic [OP_W-1:0] OP_MTHI  = 4'd12;
    localparam logic [OP_W-1:0] OP_MTLO  = 4'd13;

endpackage

//--- source/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic clk,
    input  logic reset,
    input  logic [2*core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] i_raddr,
    output logic [2*core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_rdata,
    input  logic [core_pkg::NUM_LANES-1:0] i_we,
    input  logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] i_waddr,
    input  logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] i_wdata
);
    logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

    // lane 1 goes last so it wins a shared destination
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < core_pkg::NUM_REGS; r++)
                regs[r] <= '0;
        end else begin
            for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
                if (i_we[l] && i_waddr[l] != '0)
                    regs[i_waddr[l]] <= i_wdata[l];
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2*core_pkg::NUM_LANES; p++)
            o_rdata[p] = regs[i_raddr[p]];
    end

    // r0 stays zero through every write
    generate
        for (genvar p = 0; p < 2*core_pkg::NUM_LANES; p++) begin : g_r0_chk
            assert property (@(posedge clk) disable iff (reset)
                (i_raddr[p] == '0) |-> (o_rdata[p] == '0))
                else $error("regfile: read port %0d saw nonzero r0", p);
        end
    endgenerate

endmodule

//--- source/pair_decoder.sv
`timescale 1ns/10ps

module pair_decoder (
    input  logic clk,
    input  logic reset,
    input  logic i_valid,
    input  logic [2*core_pkg::XLEN-1:0] i_instr_pair,
    input  logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] i_alu_rdst,
    input  logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] i_alu_data,
    input  logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] i_res_rdst,
    input  logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] i_res_data,
    output logic [2*core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] o_rf_raddr,
    input  logic [2*core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] i_rf_rdata,
    output logic [core_pkg::NUM_LANES-1:0] o_lane_valid,
    output logic [core_pkg::NUM_LANES-1:0][core_pkg::OP_W-1:0] o_lane_op,
    output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_lane_srca,
    output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_lane_srcb,
    output logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] o_lane_rdst
);
    logic [core_pkg::NUM_LANES-1:0][core_pkg::OP_W-1:0]       op;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] dst;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0]       imm;
    logic [core_pkg::NUM_LANES-1:0] use_rs;
    logic [core_pkg::NUM_LANES-1:0] use_rt;
    logic [core_pkg::NUM_LANES-1:0] use_imm;
    logic [2*core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] opnd;

    always_comb begin
        isa_pkg::instr_word_u word;
        for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
            word = i_instr_pair[l*core_pkg::XLEN +: core_pkg::XLEN];
            op[l]      = core_pkg::OP_NOP;
            dst[l]     = '0;
            imm[l]     = '0;
            use_rs[l]  = 1'b0;
            use_rt[l]  = 1'b0;
            use_imm[l] = 1'b0;
            o_rf_raddr[2*l]   = word.r.rs;
            o_rf_raddr[2*l+1] = word.r.rt;
            case (word.i.opcode)
                isa_pkg::OPC_SPECIAL: begin
                    case (word.r.funct)
                        isa_pkg::FN_ADDU:  op[l] = core_pkg::OP_ADDU;
                        isa_pkg::FN_SUBU:  op[l] = core_pkg::OP_SUBU;
                        isa_pkg::FN_AND:   op[l] = core_pkg::OP_AND;
                        isa_pkg::FN_OR:    op[l] = core_pkg::OP_OR;
                        isa_pkg::FN_XOR:   op[l] = core_pkg::OP_XOR;
                        isa_pkg::FN_SLT:   op[l] = core_pkg::OP_SLT;
                        isa_pkg::FN_SLTU:  op[l] = core_pkg::OP_SLTU;
                        isa_pkg::FN_MULTU: op[l] = core_pkg::OP_MULTU;
                        isa_pkg::FN_MTHI:  op[l] = core_pkg::OP_MTHI;
                        isa_pkg::FN_MTLO:  op[l] = core_pkg::OP_MTLO;
                        default:           op[l] = core_pkg::OP_NOP;
                    endcase
                    use_rs[l] = (op[l] != core_pkg::OP_NOP);
                    use_rt[l] = use_rs[l] && !(op[l] inside {core_pkg::OP_MTHI,
                                                             core_pkg::OP_MTLO});
                    // three-register forms write rd
                    if (use_rt[l] && op[l] != core_pkg::OP_MULTU)
                        dst[l] = word.r.rd;
                end
                isa_pkg::OPC_SPECIAL2: begin
                    if (word.r.funct == isa_pkg::FN2_MADDU)
                        op[l] = core_pkg::OP_MADDU;
                    else if (word.r.funct == isa_pkg::FN2_MSUBU)
                        op[l] = core_pkg::OP_MSUBU;
                    use_rs[l] = (op[l] != core_pkg::OP_NOP);
                    use_rt[l] = use_rs[l];
                end
                isa_pkg::OPC_ADDIU, isa_pkg::OPC_SLTIU: begin
                    op[l] = (word.i.opcode == isa_pkg::OPC_ADDIU) ? core_pkg::OP_ADDU
                                                                 : core_pkg::OP_SLTU;
                    imm[l] = {{16{word.i.imm[15]}}, word.i.imm};
                    use_rs[l]  = 1'b1;
                    use_imm[l] = 1'b1;
                    dst[l]     = word.i.rt;
                end
                isa_pkg::OPC_ORI: begin
                    op[l]      = core_pkg::OP_OR;
                    imm[l]     = {16'b0, word.i.imm};
                    use_rs[l]  = 1'b1;
                    use_imm[l] = 1'b1;
                    dst[l]     = word.i.rt;
                end
                isa_pkg::OPC_LUI: begin
                    op[l]      = core_pkg::OP_LUI;
                    imm[l]     = {word.i.imm, 16'b0};
                    use_imm[l] = 1'b1;
                    dst[l]     = word.i.rt;
                end
                default: op[l] = core_pkg::OP_NOP;
            endcase
        end
    end

    // newest producer wins, lane 1 ALU first
    always_comb begin
        for (int s = 0; s < 2*core_pkg::NUM_LANES; s++) begin
            opnd[s] = i_rf_rdata[s];
            for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
                if (i_res_rdst[l] != '0 && i_res_rdst[l] == o_rf_raddr[s])
                    opnd[s] = i_res_data[l];
            end
            for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
                if (i_alu_rdst[l] != '0 && i_alu_rdst[l] == o_rf_raddr[s])
                    opnd[s] = i_alu_data[l];
            end
            if (o_rf_raddr[s] == '0)
                opnd[s] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_lane_valid <= '0;
        end else begin
            o_lane_valid <= {core_pkg::NUM_LANES{i_valid}};
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
            o_lane_op[l]   <= op[l];
            o_lane_srca[l] <= use_rs[l] ? opnd[2*l] : '0;
            o_lane_srcb[l] <= use_imm[l] ? imm[l] : opnd[2*l+1];
            o_lane_rdst[l] <= dst[l];
        end
    end

    // the younger word may not consume the older word's result
    assert property (@(posedge clk) disable iff (reset)
        (i_valid && dst[0] != '0) |->
            !(use_rs[1] && o_rf_raddr[2] == dst[0]) &&
            !(use_rt[1] && o_rf_raddr[3] == dst[0]))
        else $error("pair_decoder: intra-pair dependency on r%0d", dst[0]);

endmodule

//--- lane/exec_lane.sv
`timescale 1ns/10ps

module exec_lane (
    input  logic clk,
    input  logic reset,
    input  logic i_valid,
    input  logic [core_pkg::OP_W-1:0] i_op,
    input  logic [core_pkg::XLEN-1:0] i_srca,
    input  logic [core_pkg::XLEN-1:0] i_srcb,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_rdst,
    output logic [core_pkg::REG_ADDR_W-1:0] o_alu_rdst,
    output logic [core_pkg::XLEN-1:0] o_alu_data,
    output logic o_res_valid,
    output logic [core_pkg::OP_W-1:0] o_res_op,
    output logic [core_pkg::REG_ADDR_W-1:0] o_res_rdst,
    output logic [core_pkg::XLEN-1:0] o_res_data,
    output logic [2*core_pkg::XLEN-1:0] o_res_product
);
    logic [2*core_pkg::XLEN-1:0] product;
    logic hilo_op;

    always_comb begin
        case (i_op)
            core_pkg::OP_ADDU: o_alu_data = i_srca + i_srcb;
            core_pkg::OP_SUBU: o_alu_data = i_srca - i_srcb;
            core_pkg::OP_AND:  o_alu_data = i_srca & i_srcb;
            core_pkg::OP_OR:   o_alu_data = i_srca | i_srcb;
            core_pkg::OP_XOR:  o_alu_data = i_srca ^ i_srcb;
            core_pkg::OP_SLT:
                o_alu_data = {31'b0, $signed(i_srca) < $signed(i_srcb)};
            core_pkg::OP_SLTU: o_alu_data = {31'b0, i_srca < i_srcb};
            // immediate already shifted up by the decoder
            core_pkg::OP_LUI:  o_alu_data = i_srcb;
            core_pkg::OP_MTHI, core_pkg::OP_MTLO: o_alu_data = i_srca;
            default:           o_alu_data = '0;
        endcase
    end

    assign product = {32'b0, i_srca} * {32'b0, i_srcb};
    assign o_alu_rdst = i_valid ? i_rdst : '0;
    assign hilo_op = i_op inside {core_pkg::OP_MULTU, core_pkg::OP_MADDU,
                                  core_pkg::OP_MSUBU, core_pkg::OP_MTHI,
                                  core_pkg::OP_MTLO};

    always_ff @(posedge clk) begin
        if (reset) begin
            o_res_valid <= 1'b0;
            o_res_rdst  <= '0;
        end else begin
            o_res_valid <= i_valid;
            o_res_rdst  <= o_alu_rdst;
        end
    end

    always_ff @(posedge clk) begin
        o_res_op      <= i_op;
        o_res_data    <= o_alu_data;
        o_res_product <= product;
    end

    // a HI/LO op must never reach the regfile write port
    assert property (@(posedge clk) disable iff (reset)
        (i_valid && hilo_op) |-> (i_rdst == '0))
        else $error("exec_lane: HI/LO op %0d carries destination r%0d", i_op, i_rdst);

endmodule

//--- source/commit_unit.sv
`timescale 1ns/10ps

module commit_unit (
    input  logic clk,
    input  logic reset,
    input  logic [core_pkg::NUM_LANES-1:0] i_res_valid,
    input  logic [core_pkg::NUM_LANES-1:0][core_pkg::OP_W-1:0] i_res_op,
    input  logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] i_res_rdst,
    input  logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] i_res_data,
    input  logic [core_pkg::NUM_LANES-1:0][2*core_pkg::XLEN-1:0] i_res_product,
    output logic [core_pkg::NUM_LANES-1:0] o_rf_we,
    output logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] o_rf_waddr,
    output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_rf_wdata,
    output logic [core_pkg::NUM_LANES-1:0] o_commit_valid,
    output logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] o_commit_wa,
    output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_commit_wd,
    output logic [core_pkg::XLEN-1:0] o_hi,
    output logic [core_pkg::XLEN-1:0] o_lo
);
    logic [2*core_pkg::XLEN-1:0] hilo_next;

    // older lane first, younger lane builds on its result
    always_comb begin
        hilo_next = {o_hi, o_lo};
        for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
            if (i_res_valid[l]) begin
                case (i_res_op[l])
                    core_pkg::OP_MULTU: hilo_next = i_res_product[l];
                    core_pkg::OP_MADDU: hilo_next = hilo_next + i_res_product[l];
                    core_pkg::OP_MSUBU: hilo_next = hilo_next - i_res_product[l];
                    core_pkg::OP_MTHI:
                        hilo_next[2*core_pkg::XLEN-1:core_pkg::XLEN] = i_res_data[l];
                    core_pkg::OP_MTLO:
                        hilo_next[core_pkg::XLEN-1:0] = i_res_data[l];
                    default: hilo_next = hilo_next;
                endcase
            end
        end
    end

    always_comb begin
        for (int l = 0; l < core_pkg::NUM_LANES; l++) begin
            o_rf_we[l]    = i_res_valid[l] && i_res_rdst[l] != '0;
            o_rf_waddr[l] = i_res_rdst[l];
            o_rf_wdata[l] = i_res_data[l];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_commit_valid <= '0;
            o_hi           <= '0;
            o_lo           <= '0;
        end else begin
            o_commit_valid <= i_res_valid;
            {o_hi, o_lo}   <= hilo_next;
        end
    end

    always_ff @(posedge clk) begin
        o_commit_wa <= i_res_rdst;
        o_commit_wd <= i_res_data;
    end

    // nothing commits out of reset
    assert property (@(posedge clk) $fell(reset) |->
        (o_commit_valid == '0) ##1 (o_commit_valid == '0))
        else $error("commit_unit: commit valid right after reset");

endmodule

//--- source/dual_issue_backend.sv
`timescale 1ns/10ps

module dual_issue_backend (
    input  logic clk,
    input  logic reset,
    input  logic i_valid,
    input  logic [2*core_pkg::XLEN-1:0] i_instr_pair,
    output logic [core_pkg::NUM_LANES-1:0] o_commit_valid,
    output logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] o_commit_wa,
    output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_commit_wd,
    output logic [core_pkg::XLEN-1:0] o_hi,
    output logic [core_pkg::XLEN-1:0] o_lo
);
    // issue register
    logic [core_pkg::NUM_LANES-1:0] lane_valid;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::OP_W-1:0] lane_op;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] lane_srca;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] lane_srcb;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] lane_rdst;
    // forwarding taps
    logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] alu_rdst;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] alu_data;
    // lane results
    logic [core_pkg::NUM_LANES-1:0] res_valid;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::OP_W-1:0] res_op;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] res_rdst;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] res_data;
    logic [core_pkg::NUM_LANES-1:0][2*core_pkg::XLEN-1:0] res_product;
    // register file ports
    logic [2*core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] rf_raddr;
    logic [2*core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] rf_rdata;
    logic [core_pkg::NUM_LANES-1:0] rf_we;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_ADDR_W-1:0] rf_waddr;
    logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] rf_wdata;

    pair_decoder u_decoder (
        .clk, .reset, .i_valid, .i_instr_pair,
        .i_alu_rdst(alu_rdst), .i_alu_data(alu_data),
        .i_res_rdst(res_rdst), .i_res_data(res_data),
        .o_rf_raddr(rf_raddr), .i_rf_rdata(rf_rdata),
        .o_lane_valid(lane_valid), .o_lane_op(lane_op),
        .o_lane_srca(lane_srca), .o_lane_srcb(lane_srcb),
        .o_lane_rdst(lane_rdst)
    );

    for (genvar g = 0; g < core_pkg::NUM_LANES; g++) begin : g_lane
        exec_lane u_lane (
            .clk, .reset,
            .i_valid(lane_valid[g]), .i_op(lane_op[g]),
            .i_srca(lane_srca[g]), .i_srcb(lane_srcb[g]), .i_rdst(lane_rdst[g]),
            .o_alu_rdst(alu_rdst[g]), .o_alu_data(alu_data[g]),
            .o_res_valid(res_valid[g]), .o_res_op(res_op[g]),
            .o_res_rdst(res_rdst[g]), .o_res_data(res_data[g]),
            .o_res_product(res_product[g])
        );
    end

    commit_unit u_commit (
        .clk, .reset,
        .i_res_valid(res_valid), .i_res_op(res_op), .i_res_rdst(res_rdst),
        .i_res_data(res_data), .i_res_product(res_product),
        .o_rf_we(rf_we), .o_rf_waddr(rf_waddr), .o_rf_wdata(rf_wdata),
        .o_commit_valid, .o_commit_wa, .o_commit_wd, .o_hi, .o_lo
    );

    regfile u_regfile (
        .clk, .reset,
        .i_raddr(rf_raddr), .o_rdata(rf_rdata),
        .i_we(rf_we), .i_waddr(rf_waddr), .i_wdata(rf_wdata)
    );

endmodule

//--- tests/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// one expected commit: both lanes plus the HI/LO value after the pair
typedef struct packed {
    logic [4:0]  wa0;
    logic [4:0]  wa1;
    logic [31:0] wd0;
    logic [31:0] wd1;
    logic [31:0] hi;
    logic [31:0] lo;
} commit_t;

logic [31:0] model_regs [32];
logic [63:0] model_hilo;
commit_t     exp_q [$];

// architectural effect of one MIPS word, in program order
function automatic void exec_word(input logic [31:0] w, output logic [4:0] wa,
                                  output logic [31:0] wd);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [63:0] prod;
    a = model_regs[w[25:21]];
    b = model_regs[w[20:16]];
    sx = {{16{w[15]}}, w[15:0]};
    prod = {32'b0, a} * {32'b0, b};
    wa = 5'd0;
    wd = 32'd0;
    case (w[31:26])
        isa_pkg::OPC_SPECIAL: begin
            wa = w[15:11];
            case (w[5:0])
                isa_pkg::FN_ADDU:  wd = a + b;
                isa_pkg::FN_SUBU:  wd = a - b;
                isa_pkg::FN_AND:   wd = a & b;
                isa_pkg::FN_OR:    wd = a | b;
                isa_pkg::FN_XOR:   wd = a ^ b;
                isa_pkg::FN_SLT:   wd = {31'b0, $signed(a) < $signed(b)};
                isa_pkg::FN_SLTU:  wd = {31'b0, a < b};
                isa_pkg::FN_MULTU: begin
                    wa = 5'd0;
                    model_hilo = prod;
                end
                isa_pkg::FN_MTHI: begin
                    wa = 5'd0;
                    wd = a;
                    model_hilo[63:32] = a;
                end
                isa_pkg::FN_MTLO: begin
                    wa = 5'd0;
                    wd = a;
                    model_hilo[31:0] = a;
                end
                default: wa = 5'd0;
            endcase
        end
        isa_pkg::OPC_SPECIAL2: begin
            if (w[5:0] == isa_pkg::FN2_MADDU)
                model_hilo = model_hilo + prod;
            else if (w[5:0] == isa_pkg::FN2_MSUBU)
                model_hilo = model_hilo - prod;
        end
        isa_pkg::OPC_ADDIU: begin
            wa = w[20:16];
            wd = a + sx;
        end
        isa_pkg::OPC_SLTIU: begin
            wa = w[20:16];
            wd = {31'b0, a < sx};
        end
        isa_pkg::OPC_ORI: begin
            wa = w[20:16];
            wd = a | {16'b0, w[15:0]};
        end
        isa_pkg::OPC_LUI: begin
            wa = w[20:16];
            wd = {w[15:0], 16'b0};
        end
        default: wa = 5'd0;
    endcase
    if (wa != 5'd0)
        model_regs[wa] = wd;
endfunction

function automatic void model_pair(input logic [63:0] pair);
    commit_t c;
    exec_word(pair[31:0], c.wa0, c.wd0);
    exec_word(pair[63:32], c.wa1, c.wd1);
    c.hi = model_hilo[63:32];
    c.lo = model_hilo[31:0];
    exp_q.push_back(c);
endfunction

`endif

//--- tests/tb_backend.sv
`timescale 1ns/10ps

module tb_backend;

    // pairs per test: 6, 4, 3, 5, 2, 200
    localparam int N_PAIRS = 220;
    localparam int N_TESTS = 6;
    localparam int LIMIT   = N_PAIRS + 3*N_TESTS + 50;

    logic        clk;
    logic        reset;
    logic        i_valid;
    logic [63:0] i_instr_pair;
    logic [1:0]       o_commit_valid;
    logic [1:0][4:0]  o_commit_wa;
    logic [1:0][31:0] o_commit_wd;
    logic [31:0] o_hi;
    logic [31:0] o_lo;

    `include "ref_model.svh"

    string   cur_test;
    integer  seed;
    int      errors;
    int      err_at_start;
    int      tests_ok;
    int      tests_bad;
    int      cycles;
    logic    chk_en;
    commit_t exp_cur;

    dual_issue_backend dut0 (
        .clk, .reset, .i_valid, .i_instr_pair,
        .o_commit_valid, .o_commit_wa, .o_commit_wd, .o_hi, .o_lo
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {isa_pkg::OPC_SPECIAL, rs, rt, rd, 5'b0, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] opc, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [31:0] sp2(input logic [5:0] fn, input logic [4:0] rs,
                                        input logic [4:0] rt);
        return {isa_pkg::OPC_SPECIAL2, rs, rt, 10'b0, fn};
    endfunction

    // destination a word writes, zero if none
    function automatic logic [4:0] dest_of(input logic [31:0] w);
        logic [4:0] d;
        d = 5'd0;
        if (w[31:26] == isa_pkg::OPC_SPECIAL && !(w[5:0] inside
                {isa_pkg::FN_MULTU, isa_pkg::FN_MTHI, isa_pkg::FN_MTLO}))
            d = w[15:11];
        else if (w[31:26] inside {isa_pkg::OPC_ADDIU, isa_pkg::OPC_SLTIU,
                                  isa_pkg::OPC_ORI, isa_pkg::OPC_LUI})
            d = w[20:16];
        return d;
    endfunction

    function automatic bit reads_reg(input logic [31:0] w, input logic [4:0] r);
        bit rs_used;
        bit rt_used;
        rs_used = (w[31:26] != isa_pkg::OPC_LUI);
        rt_used = (w[31:26] == isa_pkg::OPC_SPECIAL2) ||
                  (w[31:26] == isa_pkg::OPC_SPECIAL &&
                   !(w[5:0] inside {isa_pkg::FN_MTHI, isa_pkg::FN_MTLO}));
        return (rs_used && w[25:21] == r) || (rt_used && w[20:16] == r);
    endfunction

    function automatic logic [31:0] random_word();
        logic [3:0]  k;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] w;
        k   = 4'($random(seed));
        rs  = {1'b0, 4'($random(seed))};
        rt  = {1'b0, 4'($random(seed))};
        rd  = {1'b0, 4'($random(seed))};
        imm = 16'($random(seed));
        case (k)
            4'd0:  w = rtype(isa_pkg::FN_ADDU, rs, rt, rd);
            4'd1:  w = rtype(isa_pkg::FN_SUBU, rs, rt, rd);
            4'd2:  w = rtype(isa_pkg::FN_AND, rs, rt, rd);
            4'd3:  w = rtype(isa_pkg::FN_OR, rs, rt, rd);
            4'd4:  w = rtype(isa_pkg::FN_XOR, rs, rt, rd);
            4'd5:  w = rtype(isa_pkg::FN_SLT, rs, rt, rd);
            4'd6:  w = rtype(isa_pkg::FN_SLTU, rs, rt, rd);
            4'd7:  w = rtype(isa_pkg::FN_MULTU, rs, rt, 5'd0);
            4'd8:  w = rtype(isa_pkg::FN_MTHI, rs, 5'd0, 5'd0);
            4'd9:  w = rtype(isa_pkg::FN_MTLO, rs, 5'd0, 5'd0);
            4'd10: w = sp2(isa_pkg::FN2_MADDU, rs, rt);
            4'd11: w = sp2(isa_pkg::FN2_MSUBU, rs, rt);
            4'd12: w = itype(isa_pkg::OPC_ADDIU, rs, rt, imm);
            4'd13: w = itype(isa_pkg::OPC_SLTIU, rs, rt, imm);
            4'd14: w = itype(isa_pkg::OPC_ORI, rs, rt, imm);
            default: w = itype(isa_pkg::OPC_LUI, 5'd0, rt, imm);
        endcase
        return w;
    endfunction

    task automatic send(input logic [31:0] w0, input logic [31:0] w1);
        @(posedge clk);
        i_valid      <= 1'b1;
        i_instr_pair <= {w1, w0};
        model_pair({w1, w0});
    endtask

    task automatic idle();
        @(posedge clk);
        i_valid <= 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        err_at_start = errors;
    endtask

    task automatic end_test();
        idle();
        while (exp_q.size() != 0)
            @(posedge clk);
        // the last commit is checked on the edge the queue ran empty
        @(posedge clk);
        if (errors == err_at_start) begin
            tests_ok++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", cur_test, errors - err_at_start);
        end
    endtask

    // load the expected commit for the outputs now on the bus
    always @(negedge clk) begin
        chk_en = 1'b0;
        if (!reset && o_commit_valid != 2'b00) begin
            if (exp_q.size() == 0) begin
                $display("Commit seen in %s with no pending instruction pair", cur_test);
                errors++;
            end else begin
                exp_cur = exp_q.pop_front();
                chk_en  = 1'b1;
            end
        end
    end

    assert property (@(posedge clk) chk_en |-> o_commit_valid == 2'b11)
        else begin
            $display("Error %s valid: expected 3 actual %0d", cur_test,
                     $sampled(o_commit_valid));
            errors++;
        end
    assert property (@(posedge clk) chk_en |-> o_commit_wa[0] == exp_cur.wa0)
        else begin
            $display("Error %s wa0: expected %0d actual %0d", cur_test,
                     $sampled(exp_cur.wa0), $sampled(o_commit_wa[0]));
            errors++;
        end
    assert property (@(posedge clk) chk_en |-> o_commit_wa[1] == exp_cur.wa1)
        else begin
            $display("Error %s wa1: expected %0d actual %0d", cur_test,
                     $sampled(exp_cur.wa1), $sampled(o_commit_wa[1]));
            errors++;
        end
    assert property (@(posedge clk) (chk_en && exp_cur.wa0 != 5'd0) |->
                     o_commit_wd[0] == exp_cur.wd0)
        else begin
            $display("Error %s wd0: expected %h actual %h", cur_test,
                     $sampled(exp_cur.wd0), $sampled(o_commit_wd[0]));
            errors++;
        end
    assert property (@(posedge clk) (chk_en && exp_cur.wa1 != 5'd0) |->
                     o_commit_wd[1] == exp_cur.wd1)
        else begin
            $display("Error %s wd1: expected %h actual %h", cur_test,
                     $sampled(exp_cur.wd1), $sampled(o_commit_wd[1]));
            errors++;
        end
    assert property (@(posedge clk) chk_en |-> o_hi == exp_cur.hi)
        else begin
            $display("Error %s hi: expected %h actual %h", cur_test,
                     $sampled(exp_cur.hi), $sampled(o_hi));
            errors++;
        end
    assert property (@(posedge clk) chk_en |-> o_lo == exp_cur.lo)
        else begin
            $display("Error %s lo: expected %h actual %h", cur_test,
                     $sampled(exp_cur.lo), $sampled(o_lo));
            errors++;
        end
    // quiet during reset and on the first edge after it
    assert property (@(posedge clk) reset |=> o_commit_valid == 2'b00)
        else begin
            $display("Commit valid went high during or right after reset");
            errors++;
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout after %0d cycles in %s", cycles, cur_test);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] w0;
        logic [31:0] w1;
        clk          = 1'b0;
        reset        = 1'b1;
        i_valid      = 1'b0;
        i_instr_pair = '0;
        seed         = 32'h4511_7a13;
        chk_en       = 1'b0;
        cur_test     = "reset";
        model_hilo   = '0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        start_test("alu_imm");
        send(itype(isa_pkg::OPC_ADDIU, 0, 1, 16'h7fff), itype(isa_pkg::OPC_ADDIU, 0, 2, 16'h8000));
        send(itype(isa_pkg::OPC_LUI, 0, 3, 16'h8001), itype(isa_pkg::OPC_ORI, 0, 4, 16'hf0f0));
        send(rtype(isa_pkg::FN_ADDU, 1, 2, 5), rtype(isa_pkg::FN_SUBU, 1, 2, 6));
        send(rtype(isa_pkg::FN_AND, 3, 4, 7), rtype(isa_pkg::FN_OR, 3, 4, 8));
        send(rtype(isa_pkg::FN_XOR, 1, 3, 9), rtype(isa_pkg::FN_SLT, 3, 1, 10));
        send(rtype(isa_pkg::FN_SLTU, 3, 1, 11), itype(isa_pkg::OPC_SLTIU, 1, 12, 16'hffff));
        end_test();

        start_test("forwarding");
        send(rtype(isa_pkg::FN_ADDU, 5, 6, 13), rtype(isa_pkg::FN_SUBU, 7, 8, 14));
        send(rtype(isa_pkg::FN_ADDU, 13, 14, 15), rtype(isa_pkg::FN_XOR, 14, 13, 16));
        send(rtype(isa_pkg::FN_OR, 15, 13, 17), rtype(isa_pkg::FN_ADDU, 16, 14, 18));
        send(rtype(isa_pkg::FN_SUBU, 18, 17, 19), rtype(isa_pkg::FN_AND, 15, 16, 20));
        end_test();

        start_test("same_dest");
        send(itype(isa_pkg::OPC_ADDIU, 0, 21, 16'd5), itype(isa_pkg::OPC_ADDIU, 0, 21, 16'd9));
        send(rtype(isa_pkg::FN_ADDU, 21, 0, 22), 32'h0);
        repeat (3) idle();
        send(rtype(isa_pkg::FN_ADDU, 21, 21, 23), 32'h0);
        end_test();

        start_test("hilo");
        send(rtype(isa_pkg::FN_MULTU, 1, 2, 0), sp2(isa_pkg::FN2_MADDU, 3, 4));
        send(sp2(isa_pkg::FN2_MSUBU, 5, 6), rtype(isa_pkg::FN_MTHI, 1, 0, 0));
        send(rtype(isa_pkg::FN_MTLO, 2, 0, 0), rtype(isa_pkg::FN_MULTU, 3, 3, 0));
        send(sp2(isa_pkg::FN2_MADDU, 1, 1), sp2(isa_pkg::FN2_MSUBU, 4, 2));
        send(rtype(isa_pkg::FN_MTHI, 7, 0, 0), rtype(isa_pkg::FN_MTLO, 8, 0, 0));
        end_test();

        start_test("r0_writes");
        send(itype(isa_pkg::OPC_ADDIU, 0, 0, 16'h1234), itype(isa_pkg::OPC_ORI, 1, 0, 16'h7));
        send(rtype(isa_pkg::FN_ADDU, 0, 0, 24), rtype(isa_pkg::FN_OR, 0, 1, 25));
        end_test();

        start_test("random");
        for (int n = 0; n < 200; n++) begin
            w0 = random_word();
            w1 = random_word();
            // younger word must not read the older one's result
            while (dest_of(w0) != 5'd0 && reads_reg(w1, dest_of(w0)))
                w1 = random_word();
            send(w0, w1);
        end
        end_test();

        if (exp_q.size() != 0) begin
            $display("%0d expected commits never appeared", exp_q.size());
            errors++;
        end
        $display("tests ok: %0d, tests with errors: %0d, total errors: %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+tests
common/isa_pkg.sv
common/core_pkg.sv
source/regfile.sv
source/pair_decoder.sv
lane/exec_lane.sv
source/commit_unit.sv
source/dual_issue_backend.sv
tests/tb_backend.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_backend
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove build output and log"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
